/* sources.f */
+incdir+common
common/link_pkg.sv
common/link_ctrl_pkg.sv
source/serializer.sv
deserializer/deserializer_controller.sv
deserializer/deserializer_datapath.sv
source/phit_link_top.sv
test/tb_phit_link.sv

/* Bender.yml */
package:
  name: phit_link

export_include_dirs:
  - common

sources:
  - files:
      - common/link_pkg.sv
      - common/link_ctrl_pkg.sv
      - source/serializer.sv
      - deserializer/deserializer_controller.sv
      - deserializer/deserializer_datapath.sv
      - source/phit_link_top.sv
  - target: test
    files:
      - test/tb_phit_link.sv

/* test/tb_phit_link.sv */
// Phit link testbench
`include "link_consts.svh"

module tb_phit_link
    import link_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    typedef phit_t phit_array_t [`LINK_PHIT_COUNT];

    localparam int timeout_cycles = 40;
    localparam int frame_period   = `LINK_PHIT_COUNT + 1;
    localparam int burst_flits    = 20;
    localparam int direct_frames  = 8;

    logic  clk;
    logic  reset;
    flit_t flit_in;
    logic  send;
    logic  ready;
    phit_t phit_out;
    logic  receive_out;
    phit_t phit_in;
    logic  receive_in;
    flit_t flit_out;
    logic  flit_valid;
    logic  rx_idle;

    logic   loopback;
    phit_t  phit_drv;
    logic   receive_drv;
    int     seed;
    int     cycle;
    int     errors;
    int     checks;
    int     flits_received;
    flit_t  exp_q [$];
    flit_t  cmp_expected;
    logic   spacing_check;
    int     burst_valids;
    int     last_valid_cycle;

    phit_link_top u_dut (
        .clk         (clk),
        .reset       (reset),
        .flit_in     (flit_in),
        .send        (send),
        .ready       (ready),
        .phit_out    (phit_out),
        .receive_out (receive_out),
        .phit_in     (phit_in),
        .receive_in  (receive_in),
        .flit_out    (flit_out),
        .flit_valid  (flit_valid),
        .rx_idle     (rx_idle)
    );

    assign phit_in    = loopback ? phit_out : phit_drv;        // Line loopback.
    assign receive_in = loopback ? receive_out : receive_drv;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Phit i of a flit, most significant first.
    function automatic phit_t expected_phit(input flit_t f, input int i);
        logic [`LINK_FLIT_WIDTH-1:0] bits;
        bits = f;
        return bits[`LINK_FLIT_WIDTH-1-i*`LINK_PHIT_WIDTH -: `LINK_PHIT_WIDTH];
    endfunction

    function automatic flit_t assemble_flit(input phit_array_t phits);
        logic [`LINK_FLIT_WIDTH-1:0] bits;
        bits = '0;
        for (int i = 0; i < `LINK_PHIT_COUNT; i++)
            bits[(`LINK_PHIT_COUNT-1-i)*`LINK_PHIT_WIDTH +: `LINK_PHIT_WIDTH] = phits[i];
        return flit_t'(bits);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic finish_run();
        $display("Checks: %0d, flits received: %0d, errors: %0d",
                 checks, flits_received, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        errors++;
        $display("Timeout at %0d ns: %s within %0d cycles", $time, what, timeout_cycles);
        finish_run();
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string what);
        checks++;
        assert (actual === expected)
        else
        begin
            errors++;
            $display("Mismatch at %0d ns: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    // Returns 2 ns after the accepting edge.
    task automatic send_flit(input flit_t f, output int accept_cycle);
        int waited;
        waited = 0;
        while (!ready)
        begin
            if (waited == timeout_cycles)
                abort_on_timeout("ready did not return");
            waited++;
            @(posedge clk);
            #2;
        end
        flit_in = f;
        send    = 1'b1;
        @(posedge clk);
        #2;
        accept_cycle = cycle;
        send         = 1'b0;
        exp_q.push_back(f);
    endtask

    task automatic wait_valid(output int seen_cycle);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!flit_valid)
        begin
            if (waited == timeout_cycles)
                abort_on_timeout("no flit_valid pulse arrived");
            waited++;
            @(negedge clk);
        end
        seen_cycle = cycle;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0)
        begin
            if (waited == timeout_cycles * burst_flits)
                abort_on_timeout("expected flits were not all received");
            waited++;
            @(posedge clk);
        end
    endtask

    task automatic drive_frame(input phit_array_t phits, input int gap);
        @(posedge clk);
        #2;
        receive_drv = 1'b1;
        for (int i = 0; i < `LINK_PHIT_COUNT; i++)
        begin
            @(posedge clk);
            #2;
            receive_drv = 1'b0;
            phit_drv    = phits[i];
        end
        for (int j = 0; j < gap; j++)
        begin
            @(posedge clk);
            #2;
            phit_drv = '0;
            @(negedge clk);
            if (j > 0)
                check_bit(rx_idle, 1'b1, "rx_idle in gap");  // First gap cycle is stop.
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Comparison
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk)
    begin
        if (!reset && spacing_check && burst_valids > 0 && burst_valids < burst_flits)
            check_bit(rx_idle, 1'b0, "rx_idle between back-to-back flits");
        if (!reset && flit_valid)
        begin
            flits_received++;
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("Unexpected flit_valid at %0d ns with no flit outstanding", $time);
            end
            else
            begin
                cmp_expected = exp_q.pop_front();
                checks++;
                assert (flit_out === cmp_expected)
                else
                begin
                    errors++;
                    $display("Mismatch at %0d ns: addr %h payload %h, expected addr %h payload %h",
                             $time, flit_out.addr, flit_out.payload,
                             cmp_expected.addr, cmp_expected.payload);
                end
            end
            if (spacing_check && burst_valids > 0)
            begin
                checks++;
                assert (cycle - last_valid_cycle == frame_period)
                else
                begin
                    errors++;
                    $display("Mismatch at %0d ns: flit spacing %0d cycles, expected %0d",
                             $time, cycle - last_valid_cycle, frame_period);
                end
            end
            if (spacing_check)
                burst_valids++;
            last_valid_cycle = cycle;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        flit_t       f;
        int          acc;
        int          seen;
        int          gap;
        phit_array_t phits;

        reset            = 1'b1;
        flit_in          = '0;
        send             = 1'b0;
        loopback         = 1'b1;
        phit_drv         = '0;
        receive_drv      = 1'b0;
        seed             = 32'heb16a05a;
        cycle            = 0;
        errors           = 0;
        checks           = 0;
        flits_received   = 0;
        spacing_check    = 1'b0;
        burst_valids     = 0;
        last_valid_cycle = 0;

        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;

        @(negedge clk);
        check_bit(ready, 1'b1, "ready after reset");
        check_bit(rx_idle, 1'b1, "rx_idle after reset");
        check_bit(receive_out, 1'b0, "receive_out after reset");
        check_bit(flit_valid, 1'b0, "flit_valid after reset");

        // Single flit with line format and latency.
        f = flit_t'($random(seed));
        @(posedge clk);
        #2;
        send_flit(f, acc);
        @(negedge clk);
        check_bit(receive_out, 1'b1, "receive_out strobe");
        for (int i = 0; i < `LINK_PHIT_COUNT; i++)
        begin
            @(negedge clk);
            check_bit(receive_out, 1'b0, "receive_out during phits");
            checks++;
            assert (phit_out === expected_phit(f, i))
            else
            begin
                errors++;
                $display("Mismatch at %0d ns: phit %0d is %h, expected %h",
                         $time, i, phit_out, expected_phit(f, i));
            end
        end
        wait_valid(seen);
        checks++;
        assert (seen - acc == frame_period)
        else
        begin
            errors++;
            $display("Mismatch at %0d ns: latency %0d cycles, expected %0d",
                     $time, seen - acc, frame_period);
        end
        @(negedge clk);
        check_bit(flit_valid, 1'b0, "flit_valid after one cycle");

        // Back-to-back burst.
        @(posedge clk);
        #2;
        spacing_check = 1'b1;
        burst_valids  = 0;
        for (int n = 0; n < burst_flits; n++)
        begin
            f = flit_t'($random(seed));
            send_flit(f, acc);
            if (n == burst_flits / 2)
            begin
                check_bit(ready, 1'b0, "ready during frame");
                flit_in = ~f;  // Must be dropped.
                send    = 1'b1;
                @(posedge clk);
                #2;
                send = 1'b0;
            end
        end
        wait_drain();
        repeat (3) @(posedge clk);
        spacing_check = 1'b0;
        checks++;
        assert (burst_valids == burst_flits)
        else
        begin
            errors++;
            $display("Mismatch at %0d ns: %0d burst flits received, expected %0d",
                     $time, burst_valids, burst_flits);
        end

        // Receiver driven by hand.
        #2;
        loopback = 1'b0;
        for (int n = 0; n < direct_frames; n++)
        begin
            for (int i = 0; i < `LINK_PHIT_COUNT; i++)
                phits[i] = phit_t'($random(seed));
            gap = 2 + ($random(seed) & 3);
            exp_q.push_back(assemble_flit(phits));
            drive_frame(phits, gap);
        end
        wait_drain();
        repeat (3) @(posedge clk);
        finish_run();
    end

endmodule

/* source/phit_link_top.sv */
// Phit link top level
module phit_link_top
    import link_pkg::*;
(
    input  logic  clk,
    input  logic  reset,

    // Transmit end.
    input  flit_t flit_in,
    input  logic  send,
    output logic  ready,
    output phit_t phit_out,
    output logic  receive_out,

    // Receive end.
    input  phit_t phit_in,
    input  logic  receive_in,
    output flit_t flit_out,
    output logic  flit_valid,
    output logic  rx_idle
);

    logic shift_en;
    logic deserializer_idle;
    logic deserializer_finish;

    ////////////////////////////////////////////////////////////////////////////
    // Transmit
    ////////////////////////////////////////////////////////////////////////////

    serializer u_serializer (
        .clk     (clk),
        .reset   (reset),
        .flit_in (flit_in),
        .send    (send),
        .ready   (ready),
        .receive (receive_out),
        .phit    (phit_out)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Receive
    ////////////////////////////////////////////////////////////////////////////

    deserializer_controller u_deser_ctrl (
        .clk                 (clk),
        .reset               (reset),
        .receive             (receive_in),
        .shift_en            (shift_en),
        .deserializer_idle   (deserializer_idle),
        .deserializer_finish (deserializer_finish)
    );

    deserializer_datapath u_deser_data (
        .clk      (clk),
        .reset    (reset),
        .shift_en (shift_en),
        .phit_in  (phit_in),
        .flit_out (flit_out)
    );

    assign flit_valid = deserializer_finish;
    assign rx_idle    = deserializer_idle;

endmodule

/* deserializer/deserializer_datapath.sv */
// Deserializer shift register
`include "link_consts.svh"

module deserializer_datapath
    import link_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  shift_en,
    input  phit_t phit_in,
    output flit_t flit_out
);

    logic [`LINK_FLIT_WIDTH-1:0] shift_reg;

    ////////////////////////////////////////////////////////////////////////////
    // Assembly
    ////////////////////////////////////////////////////////////////////////////

    // First phit works its way up to the top bits.
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            shift_reg <= '0;
        else if (shift_en)
            shift_reg <= {shift_reg[`LINK_FLIT_WIDTH-`LINK_PHIT_WIDTH-1:0], phit_in};
    end

    assign flit_out = flit_t'(shift_reg);  // Valid during finish.

    a_phit_known: assert property (
        @(posedge clk) disable iff (reset)
        shift_en |-> !$isunknown(phit_in)
    );

endmodule

/* deserializer/deserializer_controller.sv */
// Deserializer frame controller
`include "link_consts.svh"

module deserializer_controller
    import link_ctrl_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic receive,
    output logic shift_en,
    output logic deserializer_idle,
    output logic deserializer_finish
);

    localparam int cnt_width = $clog2(`LINK_PHIT_COUNT);
    localparam logic [cnt_width-1:0] counter_stop = cnt_width'(`LINK_PHIT_COUNT - 1);

    deser_state_t         current_state;
    deser_state_t         next_state;
    logic [cnt_width-1:0] counter;

    ////////////////////////////////////////////////////////////////////////////
    // Phit counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            counter <= '0;
        else if ((current_state == deser_idle) || (current_state == deser_stop))
            counter <= '0;
        else
            counter <= counter + 1'b1;  // Start counts as phit zero.
    end

    ////////////////////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            current_state <= deser_idle;
        else
            current_state <= next_state;
    end

    always_comb
    begin
        next_state = current_state;
        case (current_state)
            deser_idle:
            begin
                if (receive)
                    next_state = deser_start;
            end
            deser_start:
                next_state = deser_deserializing;
            deser_deserializing:
            begin
                if (counter == counter_stop)
                    next_state = deser_stop;
            end
            deser_stop:
            begin
                // Back-to-back frame skips idle.
                next_state = receive ? deser_start : deser_idle;
            end
            default:
                next_state = deser_idle;
        endcase
    end

    assign deserializer_idle   = (current_state == deser_idle);
    assign deserializer_finish = (current_state == deser_stop);
    assign shift_en            = (current_state == deser_start) ||
                                 (current_state == deser_deserializing);

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    a_idle_finish_excl: assert property (
        @(posedge clk) disable iff (reset)
        !(deserializer_idle && deserializer_finish)
    );

    a_finish_single: assert property (
        @(posedge clk) disable iff (reset)
        (deserializer_finish && !receive) |=> !deserializer_finish
    );

    // Every frame shifts exactly one flit worth of phits.
    a_frame_length: assert property (
        @(posedge clk) disable iff (reset)
        $rose(shift_en) |-> shift_en [*`LINK_PHIT_COUNT] ##1 deserializer_finish
    );

endmodule

/* source/serializer.sv */
// Flit to phit serializer
`include "link_consts.svh"

module serializer
    import link_pkg::*;
    import link_ctrl_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  flit_t flit_in,
    input  logic  send,
    output logic  ready,
    output logic  receive,
    output phit_t phit
);

    localparam int idx_width = $clog2(`LINK_PHIT_COUNT);
    localparam logic [idx_width-1:0] last_idx = idx_width'(`LINK_PHIT_COUNT - 1);

    ser_state_t                  state;
    ser_state_t                  next_state;
    logic [idx_width-1:0]        phit_idx;
    logic [`LINK_FLIT_WIDTH-1:0] held_bits;
    logic                        last_phit;
    logic                        accept;

    ////////////////////////////////////////////////////////////////////////////
    // Handshake
    ////////////////////////////////////////////////////////////////////////////

    assign last_phit = (state == ser_sending) && (phit_idx == last_idx);

    // Last phit cycle reopens so frames run back to back.
    assign ready  = (state == ser_idle) || last_phit;
    assign accept = send && ready;

    ////////////////////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        next_state = state;
        case (state)
            ser_idle:
            begin
                if (accept)
                    next_state = ser_announce;
            end
            ser_announce:
                next_state = ser_sending;
            ser_sending:
            begin
                if (last_phit)
                    next_state = accept ? ser_announce : ser_idle;
            end
            default:
                next_state = ser_idle;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state    <= ser_idle;
            phit_idx <= '0;
        end
        else
        begin
            state <= next_state;
            if ((state == ser_sending) && !last_phit)
                phit_idx <= phit_idx + 1'b1;
            else
                phit_idx <= '0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Flit holding register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (accept)
            held_bits <= flit_in;
        else if (state == ser_sending)
            held_bits <= held_bits << `LINK_PHIT_WIDTH;  // Next phit to the top.
    end

    assign receive = (state == ser_announce);
    assign phit    = (state == ser_sending) ?
                     held_bits[`LINK_FLIT_WIDTH-1 -: `LINK_PHIT_WIDTH] : '0;

    // A new strobe must wait for all phits of the current frame.
    a_no_strobe_mid_frame: assert property (
        @(posedge clk) disable iff (reset)
        receive |=> (!receive) [*`LINK_PHIT_COUNT]
    );

endmodule

/* common/link_ctrl_pkg.sv */
// Phit link control states
package link_ctrl_pkg;

    // Transmit side.
    typedef enum logic [1:0]
    {
        ser_idle     = 2'b00,
        ser_announce = 2'b01,   // Receive strobe cycle.
        ser_sending  = 2'b10    // One phit per cycle.
    } ser_state_t;

    // Receive side, one-hot apart from idle.
    typedef enum logic [2:0]
    {
        deser_idle          = 3'b000,
        deser_start         = 3'b001,
        deser_deserializing = 3'b010,
        deser_stop          = 3'b100
    } deser_state_t;

endpackage

/* common/link_pkg.sv */
// Phit link data types
`include "link_consts.svh"

package link_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Flit layout
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed
    {
        logic [`LINK_ADDR_WIDTH-1:0]                  addr;     // Upper bits.
        logic [`LINK_FLIT_WIDTH-`LINK_ADDR_WIDTH-1:0] payload;  // Lower bits.
    } flit_t;

    ////////////////////////////////////////////////////////////////////////////
    // Line unit
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [`LINK_PHIT_WIDTH-1:0] phit_t;

endpackage

/* common/link_consts.svh */
// Phit link dimensions
`ifndef LINK_CONSTS_SVH
`define LINK_CONSTS_SVH

// Full flit as seen by the router ports.
`define LINK_FLIT_WIDTH 32

// Width of one phit on the serial line.
`define LINK_PHIT_WIDTH 4

// Destination address in the upper half.
`define LINK_ADDR_WIDTH 16

// Phits needed to carry one flit.
`define LINK_PHIT_COUNT (`LINK_FLIT_WIDTH / `LINK_PHIT_WIDTH)

`endif
